// File: Makefile
VERILATOR ?= verilator
TOP       := rom_load_tb
FILELIST  := rom_load_top.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
PASS_MSG  := Test completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/game_loader.sv
//////////////////////////////
// game loader
// parses ines header, sequences prg and chr writes
//////////////////////////////

`timescale 1ns/1ps

module game_loader (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          download,
  input  nes_loader_pkg::rom_byte_t     in_byte,
  input  logic                          in_strobe,
  output nes_loader_pkg::rom_addr_t     wr_addr,
  output nes_loader_pkg::rom_byte_t     wr_byte,
  output logic                          wr_strobe,
  output nes_loader_pkg::mapper_flags_t mapper_flags,
  output logic                          done,
  output logic                          error
);
  import nes_loader_pkg::*;

  localparam int HDR_CNT_W = $clog2(INES_HDR_BYTES);
  localparam logic [HDR_CNT_W-1:0] HDR_LAST = HDR_CNT_W'(INES_HDR_BYTES - 1);
  localparam rom_addr_t CHR_BASE = rom_addr_t'(1) << CHR_BASE_BIT;

  loader_state_t        state;
  logic [HDR_CNT_W-1:0] hdr_cnt;     // next header byte index
  rom_byte_t            ines [INES_HDR_BYTES];
  rom_addr_t            bytes_left;  // payload bytes still due in this region
  rom_addr_t            cur_addr;
  logic                 clear;
  logic                 hdr_last;
  logic                 hdr_ok;
  logic                 in_payload;
  rom_byte_t            prg_count;
  rom_byte_t            chr_count;

  // bank count to log2 code, >64 saturates at 7
  function automatic size_code_t size_code(input rom_byte_t count);
    size_code_t code;
    int         i;
    code = 3'd7;
    for (i = 6; i >= 0; i--) begin
      if (count <= rom_byte_t'(1 << i))
        code = size_code_t'(i);  // smallest fitting power wins
    end
    return code;
  endfunction

  // download low behaves like reset
  assign clear = reset | ~download;

  assign prg_count = ines[4];
  assign chr_count = ines[5];

  assign hdr_last = (hdr_cnt == HDR_LAST);

  // magic ok, no trainer (bit 2), no four-screen (bit 3)
  assign hdr_ok = ({ines[0], ines[1], ines[2], ines[3]} == INES_MAGIC) &&
                  !ines[6][2] && !ines[6][3];

  assign in_payload = ((state == ST_PRG) || (state == ST_CHR)) && (bytes_left != '0);

  // write port straight from the byte stream
  assign wr_addr   = cur_addr;
  assign wr_byte   = in_byte;
  assign wr_strobe = in_strobe & in_payload;

  assign error = (state == ST_FAIL);

  assign mapper_flags = '{
    zero:        '0,
    has_chr_ram: (chr_count == '0),
    vertical:    ines[6][0],
    chr_size:    size_code(chr_count),
    prg_size:    size_code(prg_count),
    mapper:      {ines[7][7:4], ines[6][7:4]}
  };

  // header byte store, no reset needed
  always_ff @(posedge clk) begin
    if (!clear && (state == ST_HEADER) && in_strobe)
      ines[hdr_cnt] <= in_byte;
  end

  always_ff @(posedge clk) begin
    if (clear) begin
      state      <= ST_HEADER;
      hdr_cnt    <= '0;
      bytes_left <= '0;
      cur_addr   <= '0;  // prg starts at 0
      done       <= 1'b0;
    end else begin
      case (state)
        ST_HEADER: begin
          if (in_strobe) begin
            hdr_cnt <= hdr_cnt + 1'b1;
            if (hdr_last) begin
              // bytes 4 and 6 already stored by now
              state      <= hdr_ok ? ST_PRG : ST_FAIL;
              bytes_left <= rom_addr_t'(prg_count) << PRG_UNIT_W;
            end
          end
        end
        ST_PRG, ST_CHR: begin
          if (bytes_left != '0) begin
            if (in_strobe) begin
              bytes_left <= bytes_left - 1'b1;
              cur_addr   <= cur_addr + 1'b1;
            end
          end else if (state == ST_PRG) begin
            // prg finished, switch region
            state      <= ST_CHR;
            cur_addr   <= CHR_BASE;
            bytes_left <= rom_addr_t'(chr_count) << CHR_UNIT_W;
          end else begin
            done <= 1'b1;  // held until download drops
          end
        end
        default: begin
          // fail holds until clear
        end
      endcase
    end
  end

endmodule

// File: design/loader_write_slot.sv
//////////////////////////////
// loader write slot stage
// holds a write until the memory slot comes round
//////////////////////////////

`timescale 1ns/1ps

module loader_write_slot #(
  parameter int SLOT_PERIOD = 4
) (
  input  logic                      clk,
  input  logic                      reset,
  input  nes_loader_pkg::rom_addr_t wr_addr,
  input  nes_loader_pkg::rom_byte_t wr_byte,
  input  logic                      wr_strobe,
  output nes_loader_pkg::rom_addr_t mem_addr,
  output nes_loader_pkg::rom_byte_t mem_byte,
  output logic                      mem_wr_en
);

  localparam int CNT_W = (SLOT_PERIOD > 1) ? $clog2(SLOT_PERIOD) : 1;
  localparam logic [CNT_W-1:0] SLOT_LAST = CNT_W'(SLOT_PERIOD - 1);

  logic [CNT_W-1:0] slot_cnt;  // free running, like the console clock enable
  logic             slot_hit;
  logic             pending;   // a captured write waits for its slot

  assign slot_hit = (slot_cnt == SLOT_LAST);

  // one cycle issue, data from the pending registers
  assign mem_wr_en = pending & slot_hit;

  always_ff @(posedge clk) begin
    if (reset) begin
      slot_cnt <= '0;
    end else if (slot_hit) begin
      slot_cnt <= '0;
    end else begin
      slot_cnt <= slot_cnt + 1'b1;
    end
  end

  // new strobe wins over the slot clearing the flag
  always_ff @(posedge clk) begin
    if (reset)
      pending <= 1'b0;
    else if (wr_strobe)
      pending <= 1'b1;
    else if (slot_hit)
      pending <= 1'b0;  // issued this cycle
  end

  // latest write replaces an older one, no back-pressure
  always_ff @(posedge clk) begin
    if (wr_strobe) begin
      mem_addr <= wr_addr;
      mem_byte <= wr_byte;
    end
  end

endmodule

// File: design/nes_loader_pkg.sv
//////////////////////////////
// nes loader shared types
// address, byte, flag word and loader state
//////////////////////////////

package nes_loader_pkg;

  // cartridge memory is byte addressed, 4 MB
  localparam int ROM_ADDR_W = 22;

  typedef logic [ROM_ADDR_W-1:0] rom_addr_t;
  typedef logic [7:0]            rom_byte_t;

  // log2 of bank count, 0 means one bank or none
  typedef logic [2:0] size_code_t;

  // flag word handed to the mapper logic
  typedef struct packed {
    logic [15:0] zero;          // unused upper half
    logic        has_chr_ram;   // no chr rom in image
    logic        vertical;      // mirroring, byte 6 bit 0
    size_code_t  chr_size;
    size_code_t  prg_size;
    rom_byte_t   mapper;        // upper nibbles of bytes 7 and 6
  } mapper_flags_t;

  typedef enum logic [1:0] {
    ST_HEADER,   // collecting the 16 header bytes
    ST_PRG,      // writing prg rom from address 0
    ST_CHR,      // writing chr rom from chr base
    ST_FAIL      // bad header, wait for download low
  } loader_state_t;

  // bank sizes, 16 KB prg and 8 KB chr
  localparam int PRG_UNIT_W = 14;
  localparam int CHR_UNIT_W = 13;

  // chr region sits in the upper half of memory
  localparam int CHR_BASE_BIT = 21;

  localparam int INES_HDR_BYTES = 16;

  // "NES" followed by msdos eof
  localparam logic [31:0] INES_MAGIC = 32'h4E45_531A;

endpackage

// File: design/rom_load_top.sv
//////////////////////////////
// rom load top
// loader, write slot and cartridge memory
//////////////////////////////

`timescale 1ns/1ps

module rom_load_top #(
  parameter int ADDR_W      = 22,
  parameter int SLOT_PERIOD = 4
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          download,
  input  nes_loader_pkg::rom_byte_t     in_byte,
  input  logic                          in_strobe,
  input  logic [ADDR_W-1:0]             rd_addr,
  output nes_loader_pkg::rom_byte_t     rd_data,
  output nes_loader_pkg::mapper_flags_t mapper_flags,
  output logic                          done,
  output logic                          error
);
  import nes_loader_pkg::*;

  rom_addr_t wr_addr;    // loader side
  rom_byte_t wr_byte;
  logic      wr_strobe;
  rom_addr_t mem_addr;   // slot-aligned side
  rom_byte_t mem_byte;
  logic      mem_wr_en;
  logic      slot_reset;

  // drop any pending write when the download ends
  assign slot_reset = reset | ~download;

  game_loader loader_i (
    .clk          (clk),
    .reset        (reset),
    .download     (download),
    .in_byte      (in_byte),
    .in_strobe    (in_strobe),
    .wr_addr      (wr_addr),
    .wr_byte      (wr_byte),
    .wr_strobe    (wr_strobe),
    .mapper_flags (mapper_flags),
    .done         (done),
    .error        (error)
  );

  loader_write_slot #(.SLOT_PERIOD(SLOT_PERIOD)) slot_i (
    .clk       (clk),
    .reset     (slot_reset),
    .wr_addr   (wr_addr),
    .wr_byte   (wr_byte),
    .wr_strobe (wr_strobe),
    .mem_addr  (mem_addr),
    .mem_byte  (mem_byte),
    .mem_wr_en (mem_wr_en)
  );

  rom_memory #(.ADDR_W(ADDR_W)) mem_i (
    .clk       (clk),
    .mem_addr  (mem_addr),
    .mem_byte  (mem_byte),
    .mem_wr_en (mem_wr_en),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

endmodule

// File: design/rom_memory.sv
//////////////////////////////
// cartridge memory model
// byte array, registered read
//////////////////////////////

`timescale 1ns/1ps

module rom_memory #(
  parameter int ADDR_W = 22
) (
  input  logic                      clk,
  input  logic [ADDR_W-1:0]         mem_addr,
  input  nes_loader_pkg::rom_byte_t mem_byte,
  input  logic                      mem_wr_en,
  input  logic [ADDR_W-1:0]         rd_addr,
  output nes_loader_pkg::rom_byte_t rd_data
);
  import nes_loader_pkg::*;

  localparam int DEPTH = 1 << ADDR_W;

  rom_byte_t mem [DEPTH];

  // power-up contents, unloaded regions read as zero
  initial begin
    foreach (mem[i])
      mem[i] = '0;
  end

  // write port, fed by the slot stage
  always @(posedge clk) begin
    if (mem_wr_en)
      mem[mem_addr] <= mem_byte;
  end

  // read port for checking, one cycle latency
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// File: dv/rom_load_sva.sv
//////////////////////////////
// loader assertions, bound into game_loader
//////////////////////////////

`timescale 1ns/1ps

module rom_load_sva (
  input logic clk,
  input logic reset,
  input logic download,
  input logic in_strobe,
  input logic wr_strobe,
  input logic done,
  input logic error
);

  // payload writes only ride on an input byte of a load still running
  a_wr_needs_in: assert property (@(posedge clk) disable iff (reset)
    wr_strobe |-> (in_strobe && !done && !error))
    else $error("wr_strobe without in_strobe or after the load ended");

  // a load ends one way only
  a_done_xor_error: assert property (@(posedge clk) disable iff (reset)
    !(done && error))
    else $error("done and error high together");

  // done sticks while the download level holds
  a_done_holds: assert property (@(posedge clk) disable iff (reset)
    (done && download) |=> done)
    else $error("done dropped while download still high");

endmodule

bind game_loader rom_load_sva sva_i (
  .clk       (clk),
  .reset     (reset),
  .download  (download),
  .in_strobe (in_strobe),
  .wr_strobe (wr_strobe),
  .done      (done),
  .error     (error)
);

// File: dv/rom_load_tb.sv
//////////////////////////////
// rom load testbench
// directed ines images, flag and memory read-back checks
//////////////////////////////

`timescale 1ns/1ps

module rom_load_tb;
  import nes_loader_pkg::*;

  localparam int ADDR_W      = 22;
  localparam int SLOT_PERIOD = 4;
  localparam int CLK_PERIOD  = 4;
  localparam int PRG_BANK    = 1 << PRG_UNIT_W;
  localparam int CHR_BANK    = 1 << CHR_UNIT_W;
  localparam int CHR_BASE    = 1 << CHR_BASE_BIT;
  localparam int KIND_PRG    = 0;  // read-back compares against prg model
  localparam int KIND_CHR    = 1;
  localparam int KIND_ZERO   = 2;  // region never written
  // six headers, four stray bytes, 3+1+1 prg banks, one chr bank
  localparam int TOTAL_BYTES = 6 * INES_HDR_BYTES + 4 + 5 * PRG_BANK + CHR_BANK;
  localparam int TOTAL_READS = 1 + 5 * PRG_BANK + 2 * CHR_BANK;
  localparam int WATCHDOG_CYCLES =
    2 * (TOTAL_BYTES * (SLOT_PERIOD + 1) + 2 * TOTAL_READS) + 1000;  // 2x margin

  logic              clk;
  logic              reset;
  logic              download;
  rom_byte_t         in_byte;
  logic              in_strobe;
  logic [ADDR_W-1:0] rd_addr;
  rom_byte_t         rd_data;
  mapper_flags_t     mapper_flags;
  logic              done;
  logic              error;

  int        seed;
  rom_byte_t header    [INES_HDR_BYTES];
  rom_byte_t prg_model [3 * PRG_BANK];  // largest image is 3 prg banks
  rom_byte_t chr_model [CHR_BANK];

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(2)) clk_gen_i (
    .clk   (clk),
    .reset (reset)
  );

  rom_load_top #(.ADDR_W(ADDR_W), .SLOT_PERIOD(SLOT_PERIOD)) dut_i (
    .clk          (clk),
    .reset        (reset),
    .download     (download),
    .in_byte      (in_byte),
    .in_strobe    (in_strobe),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .mapper_flags (mapper_flags),
    .done         (done),
    .error        (error)
  );

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
      $display("Test failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // drive point, 1 ns past the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // one strobe, then idle so the slot stage issues before the next byte
  task automatic send_byte(input rom_byte_t b);
    next_cycle();
    in_byte   = b;
    in_strobe = 1'b1;
    next_cycle();
    in_strobe = 1'b0;
    repeat (SLOT_PERIOD - 1) next_cycle();
  endtask

  task automatic make_header(input rom_byte_t prg, input rom_byte_t chr,
                             input rom_byte_t f6, input rom_byte_t f7);
    int i;
    for (i = 0; i < INES_HDR_BYTES; i++)
      header[i] = 8'h00;
    {header[0], header[1], header[2], header[3]} = 32'h4E45_531A;  // "NES" eof
    header[4] = prg;
    header[5] = chr;
    header[6] = f6;
    header[7] = f7;
  endtask

  task automatic send_header();
    int i;
    for (i = 0; i < INES_HDR_BYTES; i++)
      send_byte(header[i]);
  endtask

  // random payload, kept in the model for read-back
  task automatic send_payload(input int prg_bytes, input int chr_bytes);
    int i;
    for (i = 0; i < prg_bytes; i++) begin
      prg_model[i] = rom_byte_t'($random(seed));
      send_byte(prg_model[i]);
    end
    for (i = 0; i < chr_bytes; i++) begin
      chr_model[i] = rom_byte_t'($random(seed));
      send_byte(chr_model[i]);
    end
  endtask

  // low then high again, loader starts over
  task automatic restart_download();
    next_cycle();
    download = 1'b0;
    repeat (2) next_cycle();
    download = 1'b1;
    next_cycle();
  endtask

  task automatic wait_flag(input string name, input int max_cycles);
    int n;
    n = 0;
    while (((name == "done") ? done : error) !== 1'b1 && n < max_cycles) begin
      next_cycle();
      n++;
    end
    if (((name == "done") ? done : error) !== 1'b1) begin
      $display("timeout: %s did not rise within %0d cycles", name, max_cycles);
      $display("Test failed");
      $fatal(1, "stopped on timeout");
    end
  endtask

  // expected flag word, field values worked out by the test
  task automatic compare_flags(input rom_byte_t mapper, input logic vertical,
                               input logic chr_ram, input size_code_t prg_code,
                               input size_code_t chr_code);
    mapper_flags_t exp;
    exp             = '0;
    exp.has_chr_ram = chr_ram;
    exp.vertical    = vertical;
    exp.chr_size    = chr_code;
    exp.prg_size    = prg_code;
    exp.mapper      = mapper;
    check("mapper_flags", 32'(mapper_flags), 32'(exp));
  endtask

  task automatic read_back_region(input int base, input int count, input int kind);
    int        i;
    rom_byte_t exp;
    for (i = 0; i < count; i++) begin
      next_cycle();
      rd_addr = ADDR_W'(base + i);
      next_cycle();  // registered read
      case (kind)
        KIND_PRG: exp = prg_model[i];
        KIND_CHR: exp = chr_model[i];
        default:  exp = 8'h00;
      endcase
      check($sformatf("rd_data @%h", base + i), 32'(rd_data), 32'(exp));
    end
  endtask

  task automatic reject_bad_magic();
    int i;
    restart_download();
    make_header(8'd1, 8'd1, 8'h00, 8'h00);
    header[2] = 8'h54;  // "NET"
    send_header();
    wait_flag("error", 4);
    for (i = 0; i < 4; i++)
      send_byte(rom_byte_t'($random(seed)));  // ignored after fail
    check("error", 32'(error), 32'd1);
    check("done", 32'(done), 32'd0);
    read_back_region(0, 1, KIND_ZERO);
  endtask

  task automatic reject_bad_flags();
    restart_download();
    make_header(8'd1, 8'd1, 8'h04, 8'h00);  // trainer
    send_header();
    wait_flag("error", 4);
    check("done", 32'(done), 32'd0);
    restart_download();
    make_header(8'd1, 8'd1, 8'h08, 8'h00);  // four-screen
    send_header();
    wait_flag("error", 4);
    check("done", 32'(done), 32'd0);
  endtask

  task automatic load_chr_ram_image();
    restart_download();
    make_header(8'd3, 8'd0, 8'hA0, 8'h10);  // mapper 0x1a, horizontal
    send_header();
    check("error", 32'(error), 32'd0);
    compare_flags(8'h1A, 1'b0, 1'b1, 3'd2, 3'd0);  // 3 banks round up to 4
    send_payload(3 * PRG_BANK, 0);
    wait_flag("done", 8);
    check("error", 32'(error), 32'd0);
    read_back_region(0, 3 * PRG_BANK, KIND_PRG);
    read_back_region(CHR_BASE, CHR_BANK, KIND_ZERO);
  endtask

  task automatic load_valid_image();
    restart_download();
    make_header(8'd1, 8'd1, 8'h31, 8'h40);  // mapper 0x43, vertical
    send_header();
    compare_flags(8'h43, 1'b1, 1'b0, 3'd0, 3'd0);
    send_payload(PRG_BANK, CHR_BANK);
    wait_flag("done", 8);
    check("error", 32'(error), 32'd0);
    compare_flags(8'h43, 1'b1, 1'b0, 3'd0, 3'd0);
    read_back_region(0, PRG_BANK, KIND_PRG);
    read_back_region(CHR_BASE, CHR_BANK, KIND_CHR);
  endtask

  // follows load_valid_image, done still high on entry
  task automatic reload_image();
    check("done", 32'(done), 32'd1);
    next_cycle();
    download = 1'b0;
    next_cycle();
    check("done", 32'(done), 32'd0);
    download = 1'b1;
    make_header(8'd1, 8'd0, 8'h00, 8'h00);
    send_header();
    send_payload(PRG_BANK, 0);
    wait_flag("done", 8);
    read_back_region(0, PRG_BANK, KIND_PRG);  // new bytes over old prg
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
    $display("Test failed");
    $fatal(1, "stopped by watchdog");
  end

  initial begin
    seed      = 32'h2969;
    download  = 1'b0;
    in_byte   = '0;
    in_strobe = 1'b0;
    rd_addr   = '0;
    wait (reset == 1'b0);
    next_cycle();
    // bad images first, memory still blank
    reject_bad_magic();
    reject_bad_flags();
    load_chr_ram_image();  // chr region must still be blank here
    load_valid_image();
    reload_image();
    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: dv/tb_clock_gen.sv
//////////////////////////////
// testbench clock and reset
//////////////////////////////

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;  // 50% duty
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b0;  // release off the edge
  end

endmodule

// File: rom_load_top.f
design/nes_loader_pkg.sv
design/game_loader.sv
design/loader_write_slot.sv
design/rom_memory.sv
design/rom_load_top.sv
dv/tb_clock_gen.sv
dv/rom_load_sva.sv
dv/rom_load_tb.sv
